/* hw/cache_dir_pkg.sv */
/*
 * cache directory package
 * command kinds, address field geometry and the command word union
 * that is read either as an address or as a set/way maintenance target
 */
package cache_dir_pkg;

    // command word geometry
    parameter int ADDR_W      = 16;
    parameter int OFFSET_W    = 4;
    parameter int SET_W       = 3;
    parameter int TAG_W       = 9;
    parameter int WAY_FIELD_W = 3;

    // bits left over above the way field in the maintenance view
    parameter int SETWAY_PAD_W = ADDR_W - WAY_FIELD_W - SET_W - OFFSET_W;

    // lookups first, maintenance after
    typedef enum logic [1:0] {
        CMD_READ        = 2'd0,
        CMD_WRITE       = 2'd1,
        CMD_REFILL_DONE = 2'd2,
        CMD_INVAL       = 2'd3
    } cmd_kind_e;

    // one 16-bit word, two readings
    // set field lands on the same bits in both
    typedef union packed {
        // lookup view
        struct packed {
            logic [TAG_W-1:0]    tag;
            logic [SET_W-1:0]    set;
            logic [OFFSET_W-1:0] offset;
        } addr;
        // maintenance view, names one line by set and way
        struct packed {
            logic [SETWAY_PAD_W-1:0] pad_hi;
            logic [WAY_FIELD_W-1:0]  way;
            logic [SET_W-1:0]        set;
            logic [OFFSET_W-1:0]     pad_lo;
        } setway;
    } cmd_word_u;

endpackage

/* hw/cache_req_decode.sv */
/*
 * command decoder
 * splits the command word into set, tag and strobes, and turns the
 * maintenance way index into a one-hot select
 */
`timescale 1ns/1ps

module cache_req_decode
    import cache_dir_pkg::*;
#(
    parameter int WAYS = 4
)
(
    input  logic             cmd_valid_i,
    input  cmd_kind_e        cmd_kind_i,
    input  cmd_word_u        cmd_word_i,

    output logic [SET_W-1:0] set_o,
    output logic [TAG_W-1:0] tag_o,
    output logic             lookup_o,
    output logic             write_o,
    output logic             refill_o,
    output logic             inval_o,
    output logic [WAYS-1:0]  maint_way_o
);

    logic is_lookup;
    logic is_maint;

    assign is_lookup = (cmd_kind_i == CMD_READ) || (cmd_kind_i == CMD_WRITE);
    assign is_maint  = (cmd_kind_i == CMD_REFILL_DONE) || (cmd_kind_i == CMD_INVAL);

    // strobes only live for a valid command
    assign lookup_o = cmd_valid_i & is_lookup;
    assign write_o  = cmd_valid_i & (cmd_kind_i == CMD_WRITE);
    assign refill_o = cmd_valid_i & (cmd_kind_i == CMD_REFILL_DONE);
    assign inval_o  = cmd_valid_i & (cmd_kind_i == CMD_INVAL);

    // pick the view that matches the kind
    always_comb
    begin
        if (is_maint)
        begin
            set_o = cmd_word_i.setway.set;
            // maintenance carries no tag
            tag_o = '0;
        end
        else
        begin
            set_o = cmd_word_i.addr.set;
            tag_o = cmd_word_i.addr.tag;
        end
    end

    // way index to one-hot
    // an index past WAYS selects nothing
    always_comb
    begin
        maint_way_o = '0;
        for (int i = 0; i < WAYS; i++)
        begin
            maint_way_o[i] = is_maint && (cmd_word_i.setway.way == WAY_FIELD_W'(i));
        end
    end

endmodule

/* hw/cache_dir_way.sv */
/*
 * directory way
 * valid, dirty, fetch and tag state for every set of one way,
 * with the tag compare for the indexed set
 */
`timescale 1ns/1ps

module cache_dir_way
    import cache_dir_pkg::*;
(
    input  logic             clk_i,
    input  logic             rst_ni,

    // indexed set and lookup tag
    input  logic [SET_W-1:0] set_i,
    input  logic [TAG_W-1:0] tag_i,

    // updates from the resolver
    input  logic             alloc_i,
    input  logic             alloc_dirty_i,
    input  logic             dirty_i,

    // maintenance from the decoder
    input  logic             refill_i,
    input  logic             inval_i,
    input  logic             maint_sel_i,

    // state of the indexed set
    output logic             valid_o,
    output logic             dirty_o,
    output logic             fetch_o,
    output logic             match_o,
    output logic [TAG_W-1:0] tag_o
);

    localparam int SETS = 1 << SET_W;

    logic [SETS-1:0]  valid_q;
    logic [SETS-1:0]  dirty_q;
    logic [SETS-1:0]  fetch_q;
    logic [TAG_W-1:0] tag_q [SETS];

    // combinational read of the indexed set
    assign valid_o = valid_q[set_i];
    assign dirty_o = dirty_q[set_i];
    assign fetch_o = fetch_q[set_i];
    assign tag_o   = tag_q[set_i];

    // stale tags of invalid lines never match
    assign match_o = valid_q[set_i] && (tag_q[set_i] == tag_i);

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            valid_q <= '0;
            dirty_q <= '0;
            fetch_q <= '0;
        end
        else if (maint_sel_i && inval_i)
        begin
            // invalidate drops the whole line
            valid_q[set_i] <= 1'b0;
            dirty_q[set_i] <= 1'b0;
            fetch_q[set_i] <= 1'b0;
        end
        else if (maint_sel_i && refill_i && fetch_q[set_i])
        begin
            // refill lands, line becomes usable
            fetch_q[set_i] <= 1'b0;
        end
        else if (alloc_i)
        begin
            // miss allocation, line stays busy until refill done
            valid_q[set_i] <= 1'b1;
            fetch_q[set_i] <= 1'b1;
            dirty_q[set_i] <= alloc_dirty_i;
        end
        else if (dirty_i)
        begin
            // write hit
            dirty_q[set_i] <= 1'b1;
        end
    end

    // tag array, written only on allocation
    always_ff @(posedge clk_i)
    begin
        if (alloc_i)
        begin
            tag_q[set_i] <= tag_i;
        end
    end

endmodule

/* hw/cache_victim_cyclic.sv */
/*
 * cyclic victim selection
 * unused ways first, then the way under the cyclic pointer,
 * then the lowest clean way, then the lowest dirty way
 */
`timescale 1ns/1ps

module cache_victim_cyclic
#(
    parameter int WAYS = 4
)
(
    input  logic            clk_i,
    input  logic            rst_ni,

    input  logic            sel_victim_i,
    input  logic [WAYS-1:0] dir_valid_i,
    input  logic [WAYS-1:0] dir_dirty_i,
    input  logic [WAYS-1:0] dir_fetch_i,
    output logic [WAYS-1:0] victim_way_o
);

    localparam int PTR_W = (WAYS > 1) ? $clog2(WAYS) : 1;

    // lowest set bit as one-hot
    function automatic logic [WAYS-1:0] prio_1hot(input logic [WAYS-1:0] vec);
        logic [WAYS-1:0] res;
        logic            found;
        res   = '0;
        found = 1'b0;
        for (int i = 0; i < WAYS; i++)
        begin
            if (vec[i] && !found)
            begin
                res[i] = 1'b1;
                found  = 1'b1;
            end
        end
        return res;
    endfunction

    // pointer value to one-hot
    function automatic logic [WAYS-1:0] ptr_1hot(input logic [PTR_W-1:0] ptr);
        logic [WAYS-1:0] res;
        res = '0;
        for (int i = 0; i < WAYS; i++)
        begin
            res[i] = (ptr == PTR_W'(i));
        end
        return res;
    endfunction

    logic [PTR_W-1:0] cyclic_ptr_q;
    logic [WAYS-1:0]  unused_ways;
    logic [WAYS-1:0]  clean_ways;
    logic [WAYS-1:0]  dirty_ways;
    logic [WAYS-1:0]  cyclic_way;
    logic             unused_avail;
    logic             cyclic_avail;
    logic             clean_avail;
    logic             dirty_avail;

    // candidate classes, fetching ways are never victims
    assign unused_ways = ~dir_fetch_i & ~dir_valid_i;
    assign clean_ways  = ~dir_fetch_i &  dir_valid_i & ~dir_dirty_i;
    assign dirty_ways  = ~dir_fetch_i &  dir_valid_i &  dir_dirty_i;
    assign cyclic_way  = ptr_1hot(cyclic_ptr_q);

    assign unused_avail = |unused_ways;
    assign cyclic_avail = |(cyclic_way & ~dir_fetch_i & dir_valid_i);
    assign clean_avail  = |clean_ways;
    assign dirty_avail  = |dirty_ways;

    always_comb
    begin
        if (unused_avail)
            victim_way_o = prio_1hot(unused_ways);
        else if (cyclic_avail)
            victim_way_o = cyclic_way;
        else if (clean_avail)
            victim_way_o = prio_1hot(clean_ways);
        else if (dirty_avail)
            victim_way_o = prio_1hot(dirty_ways);
        else
            victim_way_o = '0;
    end

    // pointer moves only when a valid line has to go
    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            cyclic_ptr_q <= '0;
        end
        else if (sel_victim_i && !unused_avail)
        begin
            if (cyclic_ptr_q == PTR_W'(WAYS - 1))
                cyclic_ptr_q <= '0;
            else
                cyclic_ptr_q <= cyclic_ptr_q + 1'b1;
        end
    end

endmodule

/* hw/cache_dir_resolve.sv */
/*
 * directory resolver
 * classifies lookups as hit, busy or miss, allocates a victim on a
 * miss, marks write hits dirty and registers the response
 */
`timescale 1ns/1ps

module cache_dir_resolve
    import cache_dir_pkg::*;
#(
    parameter int WAYS = 4
)
(
    input  logic                       clk_i,
    input  logic                       rst_ni,

    input  logic                       lookup_i,
    input  logic                       write_i,

    // per-way state of the indexed set
    input  logic [WAYS-1:0]            way_valid_i,
    input  logic [WAYS-1:0]            way_dirty_i,
    input  logic [WAYS-1:0]            way_fetch_i,
    input  logic [WAYS-1:0]            way_match_i,
    input  logic [WAYS-1:0][TAG_W-1:0] way_tag_i,

    // updates back to the ways
    output logic [WAYS-1:0]            alloc_way_o,
    output logic                       alloc_dirty_o,
    output logic [WAYS-1:0]            dirty_way_o,

    // registered response
    output logic                       rsp_valid_o,
    output logic                       rsp_hit_o,
    output logic                       rsp_busy_o,
    output logic [WAYS-1:0]            rsp_way_o,
    output logic                       rsp_evict_o,
    output logic [TAG_W-1:0]           rsp_evict_tag_o
);

    logic [WAYS-1:0]  hit_ways;
    logic [WAYS-1:0]  victim_way;
    logic             hit;
    logic             busy;
    logic             miss;
    logic             evict;
    logic [TAG_W-1:0] evict_tag;

    // match already implies valid
    assign hit_ways = way_match_i & ~way_fetch_i;
    assign hit      = lookup_i & (|hit_ways);

    // line in flight, or every way waiting on a refill
    assign busy = lookup_i & ((|(way_match_i & way_fetch_i)) | (~(|hit_ways) & (&way_fetch_i)));
    assign miss = lookup_i & ~hit & ~busy;

    cache_victim_cyclic #(
        .WAYS (WAYS)
    ) u_victim (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .sel_victim_i (miss),
        .dir_valid_i  (way_valid_i),
        .dir_dirty_i  (way_dirty_i),
        .dir_fetch_i  (way_fetch_i),
        .victim_way_o (victim_way)
    );

    assign alloc_way_o   = miss ? victim_way : '0;
    assign alloc_dirty_o = miss & write_i;
    assign dirty_way_o   = (hit && write_i) ? hit_ways : '0;

    // dirty victim needs a writeback
    assign evict = miss & (|(victim_way & way_valid_i & way_dirty_i));

    // and-or mux of the victim's tag, zero when nothing is evicted
    always_comb
    begin
        evict_tag = '0;
        for (int i = 0; i < WAYS; i++)
        begin
            evict_tag = evict_tag | ({TAG_W{evict & victim_way[i]}} & way_tag_i[i]);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
            rsp_valid_o <= 1'b0;
        else
            rsp_valid_o <= lookup_i;
    end

    // response payload, captured with each lookup
    always_ff @(posedge clk_i)
    begin
        if (lookup_i)
        begin
            rsp_hit_o       <= hit;
            rsp_busy_o      <= busy;
            rsp_way_o       <= hit ? hit_ways : alloc_way_o;
            rsp_evict_o     <= evict;
            rsp_evict_tag_o <= evict_tag;
        end
    end

endmodule

/* hw/cache_dir_top.sv */
/*
 * cache tag directory top
 * command decoder, one directory block per way and the resolver
 */
`timescale 1ns/1ps

module cache_dir_top
    import cache_dir_pkg::*;
#(
    parameter int WAYS = 4
)
(
    input  logic             clk_i,
    input  logic             rst_ni,

    input  logic             cmd_valid_i,
    input  cmd_kind_e        cmd_kind_i,
    input  cmd_word_u        cmd_word_i,

    output logic             rsp_valid_o,
    output logic             rsp_hit_o,
    output logic             rsp_busy_o,
    output logic [WAYS-1:0]  rsp_way_o,
    output logic             rsp_evict_o,
    output logic [TAG_W-1:0] rsp_evict_tag_o
);

    // decoder outputs
    logic [SET_W-1:0]           set;
    logic [TAG_W-1:0]           tag;
    logic                       lookup;
    logic                       write;
    logic                       refill;
    logic                       inval;
    logic [WAYS-1:0]            maint_way;

    // way state toward the resolver
    logic [WAYS-1:0]            way_valid;
    logic [WAYS-1:0]            way_dirty;
    logic [WAYS-1:0]            way_fetch;
    logic [WAYS-1:0]            way_match;
    logic [WAYS-1:0][TAG_W-1:0] way_tag;

    // resolver updates toward the ways
    logic [WAYS-1:0]            alloc_way;
    logic                       alloc_dirty;
    logic [WAYS-1:0]            dirty_way;

    cache_req_decode #(
        .WAYS (WAYS)
    ) u_decode (
        .cmd_valid_i (cmd_valid_i),
        .cmd_kind_i  (cmd_kind_i),
        .cmd_word_i  (cmd_word_i),
        .set_o       (set),
        .tag_o       (tag),
        .lookup_o    (lookup),
        .write_o     (write),
        .refill_o    (refill),
        .inval_o     (inval),
        .maint_way_o (maint_way)
    );

    for (genvar i = 0; i < WAYS; i++)
    begin : g_way
        cache_dir_way u_way (
            .clk_i         (clk_i),
            .rst_ni        (rst_ni),
            .set_i         (set),
            .tag_i         (tag),
            .alloc_i       (alloc_way[i]),
            .alloc_dirty_i (alloc_dirty),
            .dirty_i       (dirty_way[i]),
            .refill_i      (refill),
            .inval_i       (inval),
            .maint_sel_i   (maint_way[i]),
            .valid_o       (way_valid[i]),
            .dirty_o       (way_dirty[i]),
            .fetch_o       (way_fetch[i]),
            .match_o       (way_match[i]),
            .tag_o         (way_tag[i])
        );
    end

    cache_dir_resolve #(
        .WAYS (WAYS)
    ) u_resolve (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .lookup_i        (lookup),
        .write_i         (write),
        .way_valid_i     (way_valid),
        .way_dirty_i     (way_dirty),
        .way_fetch_i     (way_fetch),
        .way_match_i     (way_match),
        .way_tag_i       (way_tag),
        .alloc_way_o     (alloc_way),
        .alloc_dirty_o   (alloc_dirty),
        .dirty_way_o     (dirty_way),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_hit_o       (rsp_hit_o),
        .rsp_busy_o      (rsp_busy_o),
        .rsp_way_o       (rsp_way_o),
        .rsp_evict_o     (rsp_evict_o),
        .rsp_evict_tag_o (rsp_evict_tag_o)
    );

endmodule

/* dv/tb_clkgen.sv */
/*
 * testbench clock and reset
 * 40 ns clock, active-low reset held for the first 5 rising edges
 */
`timescale 1ns/1ps

module tb_clkgen
#(
    parameter int HALF_PERIOD  = 20,
    parameter int RESET_CYCLES = 5
)
(
    output logic clk_o,
    output logic rst_no
);

    initial
    begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // release on a rising edge, same as the stimulus
    initial
    begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

/* dv/cache_dir_asserts.sv */
/*
 * resolver protocol assertions
 * one-hot allocation, no allocation together with a dirty update,
 * and a response exactly one cycle after each lookup
 */
`timescale 1ns/1ps

module cache_dir_asserts
#(
    parameter int WAYS = 4
)
(
    input logic            clk_i,
    input logic            rst_ni,
    input logic            lookup_i,
    input logic [WAYS-1:0] alloc_way_i,
    input logic [WAYS-1:0] dirty_way_i,
    input logic            rsp_valid_i
);

    // at most one way gets the new line
    alloc_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(alloc_way_i))
        else $error("allocation selects more than one way");

    // a lookup is either a miss or a write hit, never both
    alloc_excl_dirty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !((|alloc_way_i) && (|dirty_way_i)))
        else $error("allocation and dirty update in the same cycle");

    rsp_after_lookup: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lookup_i |=> rsp_valid_i)
        else $error("lookup without a response on the next cycle");

    // no response without a lookup the cycle before
    rsp_only_after_lookup: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !lookup_i |=> !rsp_valid_i)
        else $error("response without a lookup on the previous cycle");

endmodule

bind cache_dir_resolve cache_dir_asserts #(
    .WAYS (WAYS)
) u_asserts (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .lookup_i    (lookup_i),
    .alloc_way_i (alloc_way_o),
    .dirty_way_i (dirty_way_o),
    .rsp_valid_i (rsp_valid_o)
);

/* dv/tb_top.sv */
/*
 * cache directory testbench
 * directed and random commands checked against a reference
 * directory model that predicts each response one cycle ahead
 */
`timescale 1ns/1ps

module tb_top
    import cache_dir_pkg::*;
();

    localparam int WAYS  = 4;
    localparam int SETS  = 1 << SET_W;
    localparam int EXP_W = 3 + WAYS + TAG_W;

    logic             clk;
    logic             rst_n;
    logic             cmd_valid;
    cmd_kind_e        cmd_kind;
    cmd_word_u        cmd_word;
    logic             rsp_valid;
    logic             rsp_hit;
    logic             rsp_busy;
    logic [WAYS-1:0]  rsp_way;
    logic             rsp_evict;
    logic [TAG_W-1:0] rsp_evict_tag;

    // reference directory
    logic             m_valid [SETS][WAYS];
    logic             m_dirty [SETS][WAYS];
    logic             m_fetch [SETS][WAYS];
    logic [TAG_W-1:0] m_tag   [SETS][WAYS];
    int               m_ptr;

    // expected responses in issue order: hit, busy, way, evict, evict tag
    logic [EXP_W-1:0] exp_q [$];

    integer seed;
    int     err_count;
    int     check_count;
    bit     timed_out;

    tb_clkgen u_clkgen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    cache_dir_top #(
        .WAYS (WAYS)
    ) DUT (
        .clk_i           (clk),
        .rst_ni          (rst_n),
        .cmd_valid_i     (cmd_valid),
        .cmd_kind_i      (cmd_kind),
        .cmd_word_i      (cmd_word),
        .rsp_valid_o     (rsp_valid),
        .rsp_hit_o       (rsp_hit),
        .rsp_busy_o      (rsp_busy),
        .rsp_way_o       (rsp_way),
        .rsp_evict_o     (rsp_evict),
        .rsp_evict_tag_o (rsp_evict_tag)
    );

    function automatic cmd_word_u addr_word(input logic [TAG_W-1:0] tag, input int set);
        cmd_word_u w;
        w          = '0;
        w.addr.tag = tag;
        w.addr.set = SET_W'(set);
        return w;
    endfunction

    function automatic cmd_word_u setway_word(input int way, input int set);
        cmd_word_u w;
        w            = '0;
        w.setway.way = WAY_FIELD_W'(way);
        w.setway.set = SET_W'(set);
        return w;
    endfunction

    // unused first, then the pointer way, then lowest clean, then lowest dirty
    task automatic choose_victim(input int s, output int vict);
        int unused;
        int clean;
        int dirty;
        unused = -1;
        clean  = -1;
        dirty  = -1;
        for (int w = WAYS - 1; w >= 0; w--)
        begin
            if (!m_valid[s][w] && !m_fetch[s][w])
                unused = w;
            if (m_valid[s][w] && !m_fetch[s][w] && !m_dirty[s][w])
                clean = w;
            if (m_valid[s][w] && !m_fetch[s][w] && m_dirty[s][w])
                dirty = w;
        end
        if (unused >= 0)
            vict = unused;
        else
        begin
            if (m_valid[s][m_ptr] && !m_fetch[s][m_ptr])
                vict = m_ptr;
            else if (clean >= 0)
                vict = clean;
            else
                vict = dirty;
            // pointer only moves when a valid line goes
            m_ptr = (m_ptr + 1) % WAYS;
        end
    endtask

    task automatic model_lookup(input bit wr, input logic [TAG_W-1:0] t, input int s);
        int               match_w;
        int               vict;
        bit               all_fetch;
        logic             hit;
        logic             busy;
        logic             evict;
        logic [WAYS-1:0]  way_oh;
        logic [TAG_W-1:0] etag;
        match_w   = -1;
        all_fetch = 1'b1;
        hit       = 1'b0;
        busy      = 1'b0;
        evict     = 1'b0;
        way_oh    = '0;
        etag      = '0;
        for (int w = 0; w < WAYS; w++)
        begin
            if (m_valid[s][w] && m_tag[s][w] == t)
                match_w = w;
            if (!m_fetch[s][w])
                all_fetch = 1'b0;
        end
        if (match_w >= 0 && m_fetch[s][match_w])
            busy = 1'b1;
        else if (match_w >= 0)
        begin
            hit            = 1'b1;
            way_oh[match_w] = 1'b1;
            if (wr)
                m_dirty[s][match_w] = 1'b1;
        end
        else if (all_fetch)
            busy = 1'b1;
        else
        begin
            choose_victim(s, vict);
            way_oh[vict] = 1'b1;
            if (m_valid[s][vict] && m_dirty[s][vict])
            begin
                evict = 1'b1;
                etag  = m_tag[s][vict];
            end
            m_valid[s][vict] = 1'b1;
            m_fetch[s][vict] = 1'b1;
            m_dirty[s][vict] = wr;
            m_tag[s][vict]   = t;
        end
        exp_q.push_back({hit, busy, way_oh, evict, etag});
    endtask

    task automatic model_apply(input cmd_kind_e kind, input cmd_word_u word);
        int s;
        int w;
        s = int'(word.setway.set);
        w = int'(word.setway.way);
        if (kind == CMD_READ || kind == CMD_WRITE)
            model_lookup(kind == CMD_WRITE, word.addr.tag, int'(word.addr.set));
        else if (w < WAYS)
        begin
            if (kind == CMD_INVAL)
            begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_fetch[s][w] = 1'b0;
            end
            else if (m_fetch[s][w])
                m_fetch[s][w] = 1'b0;
        end
    endtask

    task automatic send_cmd(input cmd_kind_e kind, input cmd_word_u word);
        @(posedge clk);
        model_apply(kind, word);
        cmd_valid <= 1'b1;
        cmd_kind  <= kind;
        cmd_word  <= word;
    endtask

    task automatic go_idle;
        @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    task automatic check_field(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp)
        else
        begin
            $display("mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
            err_count++;
        end
    endtask

    // outputs settle after the rising edge, so look at the falling one
    always @(negedge clk)
    begin : check_rsp
        logic             e_hit;
        logic             e_busy;
        logic             e_evict;
        logic [WAYS-1:0]  e_way;
        logic [TAG_W-1:0] e_tag;
        if (rst_n && rsp_valid)
        begin
            assert (exp_q.size() != 0)
            else
            begin
                $display("response at %0t with no lookup outstanding", $time);
                err_count++;
            end
            if (exp_q.size() != 0)
            begin
                {e_hit, e_busy, e_way, e_evict, e_tag} = exp_q.pop_front();
                check_count++;
                check_field("hit", 16'(rsp_hit), 16'(e_hit));
                check_field("busy", 16'(rsp_busy), 16'(e_busy));
                check_field("way", 16'(rsp_way), 16'(e_way));
                check_field("evict", 16'(rsp_evict), 16'(e_evict));
                check_field("evict tag", 16'(rsp_evict_tag), 16'(e_tag));
            end
        end
    end

    task automatic wait_reset_release;
        int cycles;
        cycles = 0;
        while (!rst_n && cycles < 50)
        begin
            @(posedge clk);
            cycles++;
        end
        if (!rst_n)
        begin
            $display("timeout: reset never released");
            timed_out = 1'b1;
        end
    endtask

    task automatic drain_responses;
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 20)
        begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0)
        begin
            $display("timeout: %0d responses never arrived", exp_q.size());
            timed_out = 1'b1;
        end
    endtask

    task automatic finish_test(input string name, input int err0, input int chk0);
        go_idle();
        drain_responses();
        $display("test %s done: %0d responses, %0d errors", name,
                 check_count - chk0, err_count - err0);
    endtask

    task automatic test_fill;
        int e0;
        int c0;
        e0 = err_count;
        c0 = check_count;
        for (int i = 0; i < WAYS; i++)
            send_cmd(CMD_READ, addr_word(TAG_W'(16 * i + 5), 1));
        // lines still in flight
        send_cmd(CMD_READ, addr_word(TAG_W'(5), 1));
        send_cmd(CMD_WRITE, addr_word(TAG_W'(37), 1));
        // every way fetching, new tag has nowhere to go
        send_cmd(CMD_READ, addr_word(TAG_W'(9'h1f0), 1));
        send_cmd(CMD_READ, addr_word(TAG_W'(5), 5));
        finish_test("fill", e0, c0);
    endtask

    task automatic test_hit_after_refill;
        int e0;
        int c0;
        e0 = err_count;
        c0 = check_count;
        for (int i = 0; i < WAYS; i++)
            send_cmd(CMD_REFILL_DONE, setway_word(i, 1));
        // second refill on a settled line does nothing
        send_cmd(CMD_REFILL_DONE, setway_word(0, 1));
        send_cmd(CMD_READ, addr_word(TAG_W'(5), 1));
        send_cmd(CMD_WRITE, addr_word(TAG_W'(5), 1));
        send_cmd(CMD_READ, addr_word(TAG_W'(5), 1));
        send_cmd(CMD_READ, addr_word(TAG_W'(37), 1));
        finish_test("hit", e0, c0);
    endtask

    task automatic test_cyclic_evict;
        int e0;
        int c0;
        e0 = err_count;
        c0 = check_count;
        send_cmd(CMD_WRITE, addr_word(TAG_W'(21), 1));
        // ways 0 and 1 dirty, way 2 clean
        for (int i = 0; i < 3; i++)
        begin
            send_cmd(CMD_READ, addr_word(TAG_W'(200 + i), 1));
            send_cmd(CMD_REFILL_DONE, setway_word(i, 1));
        end
        finish_test("evict", e0, c0);
    endtask

    task automatic test_inval_reuse;
        int e0;
        int c0;
        e0 = err_count;
        c0 = check_count;
        send_cmd(CMD_INVAL, setway_word(1, 1));
        send_cmd(CMD_READ, addr_word(TAG_W'(201), 1));
        send_cmd(CMD_REFILL_DONE, setway_word(1, 1));
        // pointer still on way 3
        send_cmd(CMD_WRITE, addr_word(TAG_W'(300), 1));
        send_cmd(CMD_REFILL_DONE, setway_word(3, 1));
        finish_test("inval", e0, c0);
    endtask

    task automatic test_random_traffic;
        int e0;
        int c0;
        int r;
        int s;
        int w;
        logic [TAG_W-1:0] t;
        e0 = err_count;
        c0 = check_count;
        for (int n = 0; n < 2000; n++)
        begin
            r = $unsigned($random(seed)) % 10;
            s = $unsigned($random(seed)) % SETS;
            w = $unsigned($random(seed)) % 5;
            // small tag pool keeps hits frequent
            t = TAG_W'(17 * ($unsigned($random(seed)) % 6) + 1);
            if (r < 4)
                send_cmd(CMD_READ, addr_word(t, s));
            else if (r < 7)
                send_cmd(CMD_WRITE, addr_word(t, s));
            else if (r < 9)
                send_cmd(CMD_REFILL_DONE, setway_word(w, s));
            else
                send_cmd(CMD_INVAL, setway_word(w, s));
        end
        finish_test("random", e0, c0);
    endtask

    initial
    begin
        cmd_valid   = 1'b0;
        cmd_kind    = CMD_READ;
        cmd_word    = '0;
        seed        = 16565;
        err_count   = 0;
        check_count = 0;
        timed_out   = 1'b0;
        m_ptr       = 0;
        for (int s = 0; s < SETS; s++)
        begin
            for (int w = 0; w < WAYS; w++)
            begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_fetch[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        wait_reset_release();
        if (!timed_out)
            test_fill();
        if (!timed_out)
            test_hit_after_refill();
        if (!timed_out)
            test_cyclic_evict();
        if (!timed_out)
            test_inval_reuse();
        if (!timed_out)
            test_random_traffic();
        $display("summary: %0d responses checked, %0d errors, timeout %0d",
                 check_count, err_count, timed_out);
        if (err_count == 0 && !timed_out)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

/* tb.f */
hw/cache_dir_pkg.sv
hw/cache_req_decode.sv
hw/cache_dir_way.sv
hw/cache_victim_cyclic.sv
hw/cache_dir_resolve.sv
hw/cache_dir_top.sv
dv/tb_clkgen.sv
dv/cache_dir_asserts.sv
dv/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the cache directory testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f -o tb_top_sim

./obj_dir/tb_top_sim | tee sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi

echo "simulation passed"
